// File: verification/rename_testdata.txt
// kind rs1 rs2 rd op pc imm, expected rs1_data rs1_tag rs2_data rs2_tag tag, commit rd data tag, n
// kind 1 inst, 2 commit, 3 flush, 4 stall n, 5 blocked n, 6 inst with same-cycle commit, 7 drop
1 1 2 3 0 100 4 0 0 0 0 1 0 0 0 0
1 3 0 5 1 104 8 0 1 0 0 2 0 0 0 0
1 5 3 7 2 108 c 0 2 0 1 3 0 0 0 0
1 7 0 9 3 10c 10 0 0 0 0 4 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 3 aaaa 1 0
1 3 5 5 0 110 14 aaaa 0 0 2 5 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 5 bbbb 2 0
1 5 3 1 0 114 18 bbbb 5 aaaa 0 6 0 0 0 0
6 1 5 2 0 118 1c cccc 0 bbbb 5 7 1 cccc 6 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5
1 2 1 4 0 120 1 0 7 cccc 0 8 0 0 0 0
1 4 0 6 0 124 2 0 8 0 0 9 0 0 0 0
1 6 4 6 0 128 3 0 9 0 8 a 0 0 0 0
1 6 0 0 3 12c 0 0 a 0 0 b 0 0 0 0
1 6 0 0 3 130 0 0 a 0 0 c 0 0 0 0
1 6 0 0 3 134 0 0 a 0 0 d 0 0 0 0
1 6 0 0 3 138 0 0 a 0 0 e 0 0 0 0
1 6 0 0 3 13c 0 0 a 0 0 f 0 0 0 0
1 6 0 0 3 140 0 0 a 0 0 1 0 0 0 0
1 6 0 0 3 144 0 0 a 0 0 2 0 0 0 0
1 6 0 0 3 148 0 0 a 0 0 3 0 0 0 0
5 0 0 0 0 150 0 0 0 0 0 0 0 0 0 3
2 0 0 0 0 0 0 0 0 0 0 0 2 dddd 7 0
1 2 5 0 0 160 0 dddd 0 bbbb 5 4 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 4 1111 8 0
2 0 0 0 0 0 0 0 0 0 0 0 6 2222 a 0
7 0 0 5 0 170 0 0 0 0 0 5 0 0 0 0
7 0 0 8 0 174 0 0 0 0 0 6 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 5 4 3 0 180 0 bbbb 0 1111 0 1 0 0 0 0
1 3 6 0 0 184 0 aaaa 1 2222 0 2 0 0 0 0

// File: build.f
+incdir+common
common/rename_pkg.sv
common/commit_if.sv
src/tag_allocator.sv
src/inst_queue.sv
regfile/regfile.sv
src/rename_top.sv
verification/rename_asserts.sv
verification/rename_tb.sv

// File: Bender.yml
package:
  name: rename_front

export_include_dirs:
  - common

sources:
  - common/rename_pkg.sv
  - common/commit_if.sv
  - src/tag_allocator.sv
  - src/inst_queue.sv
  - regfile/regfile.sv
  - src/rename_top.sv
  - target: simulation
    files:
      - verification/rename_asserts.sv
      - verification/rename_tb.sv

// File: verification/rename_tb.sv
module rename_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int REC_W = 16;
    localparam int MAX_REC = 64;
    localparam int CYCLES_PER_REC = 40;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  inst_valid;
    logic                  inst_ready;
    rename_pkg::reg_idx_t  inst_rs1;
    rename_pkg::reg_idx_t  inst_rs2;
    rename_pkg::reg_idx_t  inst_rd;
    rename_pkg::op_class_t inst_op;
    rename_pkg::data_t     inst_pc;
    rename_pkg::data_t     inst_imm;
    logic                  commit_valid;
    rename_pkg::reg_idx_t  commit_rd;
    rename_pkg::data_t     commit_data;
    rename_pkg::tag_t      commit_tag;
    logic                  dispatch_valid;
    logic                  dispatch_ready;
    rename_pkg::data_t     rs1_data;
    rename_pkg::tag_t      rs1_tag;
    rename_pkg::data_t     rs2_data;
    rename_pkg::tag_t      rs2_tag;
    rename_pkg::reg_idx_t  rd;
    rename_pkg::op_class_t op;
    rename_pkg::data_t     pc;
    rename_pkg::data_t     imm;
    rename_pkg::tag_t      tag;

    // one record is REC_W words laid out as in the data file header.
    logic [31:0] recs [MAX_REC*REC_W];
    int          n_rec;
    int          checks;
    int          errors;
    int          stall_left;
    logic        loaded;
    logic [31:0] lfsr;

    rename_top rename_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic load_inst(input int base);
        inst_rs1 = rename_pkg::reg_idx_t'(recs[base+1]);
        inst_rs2 = rename_pkg::reg_idx_t'(recs[base+2]);
        inst_rd  = rename_pkg::reg_idx_t'(recs[base+3]);
        inst_op  = rename_pkg::op_class_t'(recs[base+4][1:0]);
        inst_pc  = recs[base+5];
        inst_imm = recs[base+6];
    endtask

    // holds the instruction until the edge that takes it has passed.
    task automatic send_inst(input int base);
        logic accepted;
        load_inst(base);
        inst_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            #1;
            accepted = inst_ready;
            @(negedge clk);
        end
        inst_valid = 1'b0;
    endtask

    task automatic pulse_commit(input int base);
        commit_valid = 1'b1;
        commit_rd    = rename_pkg::reg_idx_t'(recs[base+12]);
        commit_data  = recs[base+13];
        commit_tag   = rename_pkg::tag_t'(recs[base+14]);
        @(negedge clk);
        commit_valid = 1'b0;
    endtask

    task automatic take_dispatch(input int base);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            if (stall_left > 0) begin
                dispatch_ready = 1'b0;
                stall_left--;
            end else begin
                lfsr = lfsr_step(lfsr);
                dispatch_ready = lfsr[0];
            end
            #1;
            taken = dispatch_valid && dispatch_ready;
            if (taken) begin
                compare("rs1_data", rs1_data, recs[base+7]);
                compare("rs1_tag", rs1_tag, recs[base+8]);
                compare("rs2_data", rs2_data, recs[base+9]);
                compare("rs2_tag", rs2_tag, recs[base+10]);
                compare("tag", tag, recs[base+11]);
                compare("rd", rd, recs[base+3]);
                compare("op", op, recs[base+4]);
                compare("pc", pc, recs[base+5]);
                compare("imm", imm, recs[base+6]);
            end
            @(negedge clk);
        end
        dispatch_ready = 1'b1;
    endtask

    // all tags in flight, so the instruction must wait.
    task automatic expect_blocked(input int base);
        load_inst(base);
        inst_valid = 1'b1;
        repeat (recs[base+15]) begin
            #1;
            compare("inst_ready", inst_ready, 1'b0);
            @(negedge clk);
        end
        inst_valid = 1'b0;
    endtask

    task automatic apply_flush();
        flush = 1'b1;
        @(negedge clk);
        compare("dispatch_valid", dispatch_valid, 1'b0);
        flush = 1'b0;
        dispatch_ready = 1'b1;
    endtask

    initial begin
        int kind;
        int base;
        rst = 1'b1;
        flush = 1'b0;
        inst_valid = 1'b0;
        inst_rs1 = '0;
        inst_rs2 = '0;
        inst_rd = '0;
        inst_op = rename_pkg::OP_ALU;
        inst_pc = '0;
        inst_imm = '0;
        commit_valid = 1'b0;
        commit_rd = '0;
        commit_data = '0;
        commit_tag = '0;
        dispatch_ready = 1'b1;
        loaded = 1'b0;
        checks = 0;
        errors = 0;
        stall_left = 0;
        n_rec = 0;
        lfsr = 32'ha31c_d45b;
        $readmemh("verification/rename_testdata.txt", recs);
        while (n_rec < MAX_REC && recs[n_rec*REC_W] >= 1 && recs[n_rec*REC_W] <= 7)
            n_rec++;
        loaded = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        if (n_rec == 0) begin
            $display("no records could be read from the data file");
            errors++;
        end
        for (int r = 0; r < n_rec; r++) begin
            base = r * REC_W;
            kind = recs[base];
            case (kind)
                1, 6: begin
                    send_inst(base);
                    // kind 6 commits in the cycle the register file reads.
                    if (kind == 6)
                        pulse_commit(base);
                    take_dispatch(base);
                end
                2: pulse_commit(base);
                3: apply_flush();
                4: stall_left = recs[base+15];
                5: expect_blocked(base);
                default: begin
                    dispatch_ready = 1'b0;
                    send_inst(base);
                end
            endcase
            $display("record %0d kind %0d finished, %0d errors so far", r, kind, errors);
        end
        errors += int'(rename_top_inst.rename_asserts_inst.fail_count);
        $display("%0d records, %0d checks, %0d errors", n_rec, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (16 + (n_rec + 1) * CYCLES_PER_REC) @(posedge clk);
        $display("watchdog timeout, the records did not complete in the allowed time");
        $display("Errors found");
        $finish;
    end

endmodule

// File: verification/rename_asserts.sv
module rename_asserts (
    input logic                  clk,
    input logic                  rst,
    input logic                  flush,
    input logic                  dispatch_valid,
    input logic                  dispatch_ready,
    input rename_pkg::dispatch_t dispatch_data,
    input logic                  pop,
    input rename_pkg::reg_idx_t  src_rs1,
    input rename_pkg::reg_idx_t  src_rs2
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // a stalled dispatch keeps its record until it is taken.
    hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid && !dispatch_ready && !flush |=> dispatch_valid && $stable(dispatch_data))
        else begin
            fail_count++;
            $error("dispatch record changed while dispatch_ready was low");
        end

    idle_after_reset: assert property (@(posedge clk) rst |=> !dispatch_valid)
        else begin
            fail_count++;
            $error("dispatch_valid high in the cycle after reset");
        end

    // x0 never has a pending producer.
    zero_rs1_tag: assert property (@(posedge clk) disable iff (rst)
        pop && src_rs1 == '0 |=> dispatch_data.rs1_tag == '0)
        else begin
            fail_count++;
            $error("rs1 tag not zero for register 0");
        end

    zero_rs2_tag: assert property (@(posedge clk) disable iff (rst)
        pop && src_rs2 == '0 |=> dispatch_data.rs2_tag == '0)
        else begin
            fail_count++;
            $error("rs2 tag not zero for register 0");
        end

endmodule

bind rename_top rename_asserts rename_asserts_inst (
    .clk(clk),
    .rst(rst),
    .flush(flush),
    .dispatch_valid(dispatch_valid),
    .dispatch_ready(dispatch_ready),
    .dispatch_data(dispatch_data),
    .pop(queue_valid && queue_ready),
    .src_rs1(queue_data.inst.rs1),
    .src_rs2(queue_data.inst.rs2)
);

// File: src/rename_top.sv
module rename_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  inst_valid,
    output logic                  inst_ready,
    input  rename_pkg::reg_idx_t  inst_rs1,
    input  rename_pkg::reg_idx_t  inst_rs2,
    input  rename_pkg::reg_idx_t  inst_rd,
    input  rename_pkg::op_class_t inst_op,
    input  rename_pkg::data_t     inst_pc,
    input  rename_pkg::data_t     inst_imm,
    input  logic                  commit_valid,
    input  rename_pkg::reg_idx_t  commit_rd,
    input  rename_pkg::data_t     commit_data,
    input  rename_pkg::tag_t      commit_tag,
    output logic                  dispatch_valid,
    input  logic                  dispatch_ready,
    output rename_pkg::data_t     rs1_data,
    output rename_pkg::tag_t      rs1_tag,
    output rename_pkg::data_t     rs2_data,
    output rename_pkg::tag_t      rs2_tag,
    output rename_pkg::reg_idx_t  rd,
    output rename_pkg::op_class_t op,
    output rename_pkg::data_t     pc,
    output rename_pkg::data_t     imm,
    output rename_pkg::tag_t      tag
);

    rename_pkg::inst_t        inst;
    rename_pkg::tagged_inst_t alloc_data;
    rename_pkg::tagged_inst_t queue_data;
    rename_pkg::dispatch_t    dispatch_data;
    logic                     alloc_valid;
    logic                     alloc_ready;
    logic                     queue_valid;
    logic                     queue_ready;

    commit_if commit_bus ();

    assign commit_bus.valid = commit_valid;
    assign commit_bus.rd    = commit_rd;
    assign commit_bus.data  = commit_data;
    assign commit_bus.tag   = commit_tag;

    assign inst = '{rs1: inst_rs1, rs2: inst_rs2, rd: inst_rd, op: inst_op,
                    pc: inst_pc, imm: inst_imm};

    tag_allocator tag_allocator_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
        .commit(commit_bus.sink),
        .out_valid(alloc_valid), .out_data(alloc_data), .out_ready(alloc_ready)
    );

    inst_queue #(.payload_t(rename_pkg::tagged_inst_t)) inst_queue_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(alloc_valid), .in_data(alloc_data), .in_ready(alloc_ready),
        .out_valid(queue_valid), .out_data(queue_data), .out_ready(queue_ready)
    );

    regfile regfile_inst (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(queue_valid), .in_data(queue_data), .in_ready(queue_ready),
        .commit(commit_bus.sink),
        .dispatch_valid(dispatch_valid), .dispatch_ready(dispatch_ready),
        .dispatch_data(dispatch_data)
    );

    assign rs1_data = dispatch_data.rs1_data;
    assign rs1_tag  = dispatch_data.rs1_tag;
    assign rs2_data = dispatch_data.rs2_data;
    assign rs2_tag  = dispatch_data.rs2_tag;
    assign rd       = dispatch_data.rd;
    assign op       = dispatch_data.op;
    assign pc       = dispatch_data.pc;
    assign imm      = dispatch_data.imm;
    assign tag      = dispatch_data.tag;

endmodule

// File: regfile/regfile.sv
`include "rename_cfg.svh"

module regfile (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     in_valid,
    input  rename_pkg::tagged_inst_t in_data,
    output logic                     in_ready,
    commit_if.sink                   commit,
    output logic                     dispatch_valid,
    input  logic                     dispatch_ready,
    output rename_pkg::dispatch_t    dispatch_data
);

    rename_pkg::data_t data_q [`RN_REG_NUM];
    rename_pkg::tag_t  tag_q  [`RN_REG_NUM];

    rename_pkg::reg_idx_t rs1;
    rename_pkg::reg_idx_t rs2;
    rename_pkg::reg_idx_t rd;
    rename_pkg::data_t    rs1_data;
    rename_pkg::data_t    rs2_data;
    rename_pkg::tag_t     rs1_tag;
    rename_pkg::tag_t     rs2_tag;
    logic                 commit_wr;
    logic                 pop;
    logic                 rename_rd;

    assign rs1 = in_data.inst.rs1;
    assign rs2 = in_data.inst.rs2;
    assign rd  = in_data.inst.rd;

    // output register is free when empty or being taken this cycle.
    assign in_ready = !dispatch_valid || dispatch_ready;
    assign pop      = in_valid && in_ready;

    assign commit_wr = commit.valid && (commit.rd != '0);
    assign rename_rd = pop && rename_pkg::writes_rd(in_data.inst.op) && (rd != '0);

    // same-cycle commit data is visible and a matching tag reads as cleared.
    assign rs1_data = (commit_wr && commit.rd == rs1) ? commit.data : data_q[rs1];
    assign rs2_data = (commit_wr && commit.rd == rs2) ? commit.data : data_q[rs2];
    assign rs1_tag  = (commit_wr && commit.rd == rs1 && commit.tag == tag_q[rs1]) ?
                      '0 : tag_q[rs1];
    assign rs2_tag  = (commit_wr && commit.rd == rs2 && commit.tag == tag_q[rs2]) ?
                      '0 : tag_q[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RN_REG_NUM; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
        end else begin
            // data always lands; tag clears only if no newer producer took rd.
            if (commit_wr) begin
                data_q[commit.rd] <= commit.data;
                if (tag_q[commit.rd] == commit.tag)
                    tag_q[commit.rd] <= '0;
            end
            // a rename of the same rd wins over the clear above.
            if (flush) begin
                for (int i = 0; i < `RN_REG_NUM; i++)
                    tag_q[i] <= '0;
            end else if (rename_rd) begin
                tag_q[rd] <= in_data.tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush)
            dispatch_valid <= 1'b0;
        else if (in_ready)
            dispatch_valid <= pop;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dispatch_data.rs1_data <= rs1_data;
            dispatch_data.rs1_tag  <= rs1_tag;
            dispatch_data.rs2_data <= rs2_data;
            dispatch_data.rs2_tag  <= rs2_tag;
            dispatch_data.rd       <= rd;
            dispatch_data.op       <= in_data.inst.op;
            dispatch_data.pc       <= in_data.inst.pc;
            dispatch_data.imm      <= in_data.inst.imm;
            dispatch_data.tag      <= in_data.tag;
        end
    end

endmodule

// File: src/inst_queue.sv
`include "rename_cfg.svh"

module inst_queue #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int DEPTH = `RN_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != DEPTH);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/tag_allocator.sv
`include "rename_cfg.svh"

module tag_allocator (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    inst_valid,
    input  rename_pkg::inst_t       inst,
    output logic                    inst_ready,
    commit_if.sink                  commit,
    output logic                    out_valid,
    output rename_pkg::tagged_inst_t out_data,
    input  logic                    out_ready
);

    localparam int CNT_W = $clog2(`RN_ROB_DEPTH + 1);

    rename_pkg::tag_t next_tag;
    logic [CNT_W-1:0] in_flight;
    logic             room;
    logic             accept;
    logic             release_tag;

    // nothing is taken in during a flush cycle.
    assign room        = !flush && (in_flight < `RN_ROB_DEPTH);
    assign out_valid   = inst_valid && room;
    assign inst_ready  = room && out_ready;
    assign accept      = inst_valid && inst_ready;
    assign release_tag = commit.valid && (in_flight != '0);

    assign out_data.inst = inst;
    assign out_data.tag  = next_tag;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            next_tag  <= rename_pkg::tag_t'(1);
            in_flight <= '0;
        end else begin
            if (accept) begin
                // wrap from the last tag back to 1, never to 0.
                if (next_tag == `RN_ROB_DEPTH)
                    next_tag <= rename_pkg::tag_t'(1);
                else
                    next_tag <= next_tag + 1'b1;
            end
            case ({accept, release_tag})
                2'b10: in_flight <= in_flight + 1'b1;
                2'b01: in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

endmodule

// File: common/commit_if.sv
interface commit_if;

    logic                valid;
    rename_pkg::reg_idx_t rd;
    rename_pkg::data_t    data;
    rename_pkg::tag_t     tag;

    // driven from the reorder buffer side.
    modport source (
        output valid,
        output rd,
        output data,
        output tag
    );

    // register file and tag allocator only listen.
    modport sink (
        input valid,
        input rd,
        input data,
        input tag
    );

endinterface

// File: common/rename_pkg.sv
`include "rename_cfg.svh"

package rename_pkg;

    localparam int REG_W = $clog2(`RN_REG_NUM);

    typedef logic [REG_W-1:0] reg_idx_t;
    typedef logic [`RN_DATA_W-1:0] data_t;
    typedef logic [`RN_TAG_W-1:0] tag_t;

    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } op_class_t;

    typedef struct packed {
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        reg_idx_t  rd;
        op_class_t op;
        data_t     pc;
        data_t     imm;
    } inst_t;

    typedef struct packed {
        inst_t inst;
        tag_t  tag;
    } tagged_inst_t;

    typedef struct packed {
        data_t     rs1_data;
        tag_t      rs1_tag;
        data_t     rs2_data;
        tag_t      rs2_tag;
        reg_idx_t  rd;
        op_class_t op;
        data_t     pc;
        data_t     imm;
        tag_t      tag;
    } dispatch_t;

    // stores and branches carry an rd field but produce no register result.
    function automatic logic writes_rd(op_class_t op);
        return (op == OP_ALU) || (op == OP_LOAD);
    endfunction

endpackage

// File: common/rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// architectural register file.
`define RN_REG_NUM 32
`define RN_DATA_W 32

// tag 0 is reserved, so live tags run 1..RN_ROB_DEPTH.
`define RN_TAG_W 4
`define RN_ROB_DEPTH 15
`define RN_QUEUE_DEPTH 4

`endif
